//--- emifAccessIf.sv
// One decoded window access per cycle; target read data appears one cycle after sel

`timescale 1ns/1ps

interface emifAccessIf;

  logic             sel;     // Access this cycle
  logic             wrEn;    // High for write, low for read
  emifPkg::winAddrT addr;    // Offset inside the window
  emifPkg::busByteT wrData;  // Write byte
  emifPkg::busByteT rdData;  // Read byte, held until next read

  // Decoder side
  modport host (
    output sel,
    output wrEn,
    output addr,
    output wrData,
    input  rdData
  );

  // Register file or memory side
  modport target (
    input  sel,
    input  wrEn,
    input  addr,
    input  wrData,
    output rdData
  );

endinterface

//--- emifDecoder.sv
// No stall and no back-pressure; every cycle with csN low is taken, reads return one cycle later

`timescale 1ns/1ps

module emifDecoder (
  input  logic                              shlClk,
  input  logic                              rstN,
  // External bus
  input  logic                              csN,
  input  logic                              weN,
  input  logic [emifPkg::cBusAddrWidth-1:0] addr,
  input  emifPkg::busByteT                  wrData,
  output emifPkg::busByteT                  rdData,
  output logic                              rdValid,
  // Window accesses
  emifAccessIf.host                         regAccess,
  emifAccessIf.host                         xmemAccess
);

  logic busAcc;   // Chip select active
  logic upperWin; // Upper window hit
  logic rdWin;    // Window of the read in flight

  // ----------------------------------------------------------------------
  // Steering, same cycle
  // ----------------------------------------------------------------------
  assign busAcc   = !csN;
  assign upperWin = addr[emifPkg::cBusAddrWidth-1];

  assign regAccess.sel  = busAcc && !upperWin;
  assign xmemAccess.sel = busAcc && upperWin;

  // Both windows see the same strobe and payload
  assign regAccess.wrEn    = !weN;
  assign regAccess.addr    = addr[emifPkg::cWinAddrWidth-1:0];
  assign regAccess.wrData  = wrData;
  assign xmemAccess.wrEn   = !weN;
  assign xmemAccess.addr   = addr[emifPkg::cWinAddrWidth-1:0];
  assign xmemAccess.wrData = wrData;

  // ----------------------------------------------------------------------
  // Read return
  // ----------------------------------------------------------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      rdValid <= 1'b0;
      rdWin   <= 1'b0;
    end
    else
    begin
      rdValid <= busAcc && weN;  // One result per read cycle
      rdWin   <= upperWin;
    end
  end

  // Idle bus shows zero
  assign rdData = !rdValid ? '0 : (rdWin ? xmemAccess.rdData : regAccess.rdData);

  // Only one target may act on a cycle
  oneTargetSel: assert property (@(posedge shlClk) disable iff (!rstN)
    !(regAccess.sel && xmemAccess.sel))
    else $error("both window selects high");

endmodule

//--- emifPkg.sv
// Geometry is fixed at an 8-bit bus, 128-byte windows and a 2 KiB memory; change all together

package emifPkg;

  // ----------------------------------------------------------------------
  // Bus side
  // ----------------------------------------------------------------------
  localparam int cBusAddrWidth = 8;   // Full bus address, bit 7 picks the window
  localparam int cBusDataWidth = 8;   // Byte-wide data bus
  localparam int cWinAddrWidth = 7;   // Offset inside one 128-byte window

  // ----------------------------------------------------------------------
  // Extended memory
  // ----------------------------------------------------------------------
  localparam int cRamBytes      = 2048;  // 16 pages of 128 bytes
  localparam int cRamAddrAWidth = 11;    // Byte port address
  localparam int cFabDataWidth  = 32;    // Fabric word
  localparam int cFabAddrWidth  = 9;     // Fabric word address

  // Bus byte
  typedef logic [cBusDataWidth-1:0] busByteT;

  // Window offset, same width for both windows
  typedef logic [cWinAddrWidth-1:0] winAddrT;

  // Fabric word, byte 0 in the low bits
  typedef logic [cFabDataWidth-1:0] fabWordT;

endpackage

//--- mmioClient.sv
// Single clock shlClk; split data bus with rdValid; memory always present with EMIF ID 0x3D

`timescale 1ns/1ps

module mmioClient (
  input  logic                              shlClk,
  input  logic                              rstN,
  // External memory bus
  input  logic                              csN,
  input  logic                              weN,
  input  logic [emifPkg::cBusAddrWidth-1:0] addr,
  input  emifPkg::busByteT                  wrData,
  output emifPkg::busByteT                  rdData,
  output logic                              rdValid,
  // Shell status
  input  logic [1:0]                        memCalDone,
  input  logic                              ethCoreReady,
  input  logic                              qpllLock,
  input  logic                              camReady,
  input  logic                              toeReady,
  input  logic [15:0]                       roleRdReg,
  // Shell control
  output logic [31:0]                       ipAddress,
  output logic [31:0]                       subNetMask,
  output logic [31:0]                       gatewayAddr,
  output logic [15:0]                       roleWrReg,
  output logic                              pcsLoopbackEn,
  output logic                              macLoopbackEn,
  // Fabric memory port
  input  logic                              xmemEn,
  input  logic                              xmemWrEn,
  input  logic [emifPkg::cFabAddrWidth-1:0] xmemAddr,
  input  emifPkg::fabWordT                  xmemWrData,
  output emifPkg::fabWordT                  xmemRdData
);

  emifPkg::busByteT pageSel;  // Regfile to memory

  emifAccessIf regAccess ();   // Lower window
  emifAccessIf xmemAccess ();  // Upper window

  emifDecoder decoder_inst (
    .shlClk     (shlClk),
    .rstN       (rstN),
    .csN        (csN),
    .weN        (weN),
    .addr       (addr),
    .wrData     (wrData),
    .rdData     (rdData),
    .rdValid    (rdValid),
    .regAccess  (regAccess.host),
    .xmemAccess (xmemAccess.host)
  );

  mmioRegFile regFile_inst (
    .shlClk        (shlClk),
    .rstN          (rstN),
    .regAccess     (regAccess.target),
    .memCalDone    (memCalDone),
    .ethCoreReady  (ethCoreReady),
    .qpllLock      (qpllLock),
    .camReady      (camReady),
    .toeReady      (toeReady),
    .roleRdReg     (roleRdReg),
    .ipAddress     (ipAddress),
    .subNetMask    (subNetMask),
    .gatewayAddr   (gatewayAddr),
    .roleWrReg     (roleWrReg),
    .pcsLoopbackEn (pcsLoopbackEn),
    .macLoopbackEn (macLoopbackEn),
    .pageSel       (pageSel)
  );

  xmemDpram dpram_inst (
    .shlClk     (shlClk),
    .pageSel    (pageSel),
    .xmemAccess (xmemAccess.target),
    .xmemEn     (xmemEn),
    .xmemWrEn   (xmemWrEn),
    .xmemAddr   (xmemAddr),
    .xmemWrData (xmemWrData),
    .xmemRdData (xmemRdData)
  );

endmodule

//--- mmioClientTb.sv
// Self-checking run against a shadow model; memory bytes are only read back after being written

`timescale 1ns/1ps

module mmioClientTb;

  logic             shlClk;
  logic             rstN;
  logic             csN;
  logic             weN;
  logic [7:0]       addr;
  emifPkg::busByteT wrData;
  emifPkg::busByteT rdData;
  logic             rdValid;
  logic [1:0]       memCalDone;
  logic             ethCoreReady;
  logic             qpllLock;
  logic             camReady;
  logic             toeReady;
  logic [15:0]      roleRdReg;
  logic [31:0]      ipAddress;
  logic [31:0]      subNetMask;
  logic [31:0]      gatewayAddr;
  logic [15:0]      roleWrReg;
  logic             pcsLoopbackEn;
  logic             macLoopbackEn;
  logic             xmemEn;
  logic             xmemWrEn;
  logic [8:0]       xmemAddr;
  emifPkg::fabWordT xmemWrData;
  emifPkg::fabWordT xmemRdData;

  // Shadow model with byte n of a register at element base+n
  logic [127:0][7:0] shReg;
  logic [7:0]        shMem [2048];
  logic [3:0]        shPage;
  logic [7:0]        expRead;   // Expected byte for the access on the bus now
  logic [7:0]        expReadQ;  // Held for the return cycle
  logic [31:0]       expWordQ;  // Expected fabric read word

  int    failCount   = 0;
  int    failMark    = 0;
  int    testsPassed = 0;
  int    testsFailed = 0;
  event  runAborted;
  string abortWhy;

  tbClockGen clockGen_inst (
    .shlClk (shlClk),
    .rstN   (rstN)
  );

  mmioClient mmioClient_inst (.*);

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic regWritable(input logic [6:0] off);
    return (off >= 7'h34 && off <= 7'h3F) || off == 7'h52 || off == 7'h53 ||
           (off >= 7'h70 && off <= 7'h74) || off == 7'h7F;
  endfunction

  assign shPage = shReg[7'h7F][3:0];

  always_comb
  begin
    if (addr[7])
      expRead = shMem[{shPage, addr[6:0]}];  // Paged memory byte
    else if (regWritable(addr[6:0]))
      expRead = shReg[addr[6:0]];
    else
    begin
      case (addr[6:0])
        7'h00:   expRead = 8'h3D;  // ID
        7'h01:   expRead = 8'h01;  // Version
        7'h02:   expRead = 8'h00;  // Revision
        7'h10:
        begin
          expRead      = 8'h00;         // Bits 7:6 stay clear
          expRead[1:0] = memCalDone;
          expRead[2]   = ethCoreReady;
          expRead[3]   = qpllLock;
          expRead[4]   = camReady;
          expRead[5]   = toeReady;
        end
        7'h50:   expRead = roleRdReg[7:0];
        7'h51:   expRead = roleRdReg[15:8];
        default: expRead = 8'h00;  // Unmapped
      endcase
    end
  end

  always @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      shReg              <= '0;
      shReg[7'h37:7'h34] <= 32'h13C80C0A;  // 0A 0C C8 13
      shReg[7'h3B:7'h38] <= 32'h0000FFFF;  // FF FF 00 00
      shReg[7'h3F:7'h3C] <= 32'h01000C0A;  // 0A 0C 00 01
      shReg[7'h73:7'h70] <= 32'hEFBEADDE;  // DE AD BE EF
    end
    else if (!csN && !weN && !addr[7] && regWritable(addr[6:0]))
      shReg[addr[6:0]] <= wrData;
  end

  // Memory shadow and held expectations
  always @(posedge shlClk)
  begin
    if (!csN && !weN && addr[7])
      shMem[{shPage, addr[6:0]}] <= wrData;
    if (xmemEn && xmemWrEn)
    begin
      for (int k = 0; k < 4; k++)
        shMem[{xmemAddr, 2'(k)}] <= xmemWrData[8*k +: 8];
    end
    if (!csN && weN)
      expReadQ <= expRead;
    if (xmemEn && !xmemWrEn)
      expWordQ <= {shMem[{xmemAddr, 2'd3}], shMem[{xmemAddr, 2'd2}],
                   shMem[{xmemAddr, 2'd1}], shMem[{xmemAddr, 2'd0}]};
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  readData: assert property (@(posedge shlClk) disable iff (!rstN)
    (!csN && weN) |=> (rdValid && rdData == expReadQ))
    else
    begin
      failCount++;
      $display("[FAIL] %0t ns: read returned %02h valid %b, expected %02h",
               $time, rdData, rdValid, expReadQ);
    end

  noSpuriousValid: assert property (@(posedge shlClk) disable iff (!rstN)
    rdValid |-> $past(!csN && weN))
    else
    begin
      failCount++;
      $display("[FAIL] %0t ns: rdValid high without a read before it", $time);
    end

  ctrlOutputs: assert property (@(posedge shlClk) disable iff (!rstN)
    ipAddress == shReg[7'h37:7'h34] && subNetMask == shReg[7'h3B:7'h38] &&
    gatewayAddr == shReg[7'h3F:7'h3C] && roleWrReg == shReg[7'h53:7'h52] &&
    pcsLoopbackEn == shReg[7'h74][0] && macLoopbackEn == shReg[7'h74][1])
    else
    begin
      failCount++;
      $display("[FAIL] %0t ns: control outputs ip %h mask %h gw %h role %h lb %b%b",
               $time, ipAddress, subNetMask, gatewayAddr, roleWrReg,
               macLoopbackEn, pcsLoopbackEn);
    end

  fabricRead: assert property (@(posedge shlClk) disable iff (!rstN)
    (xmemEn && !xmemWrEn) |=> xmemRdData == expWordQ)
    else
    begin
      failCount++;
      $display("[FAIL] %0t ns: fabric read %h, expected %h", $time, xmemRdData, expWordQ);
    end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic nextCycle();
    @(posedge shlClk);
    #1;  // Drive just after the edge
  endtask

  task automatic waitReadValid();
    int n;
    n = 0;
    while (!rdValid && n < 16)
    begin
      nextCycle();
      n++;
    end
    if (!rdValid)
    begin
      abortWhy = "rdValid never came back after a bus read";
      -> runAborted;
    end
  endtask

  task automatic busWrite(input logic [7:0] a, input logic [7:0] d);
    csN    = 1'b0;
    weN    = 1'b0;
    addr   = a;
    wrData = d;
    nextCycle();
    csN = 1'b1;
    weN = 1'b1;
  endtask

  task automatic busRead(input logic [7:0] a);
    csN  = 1'b0;
    weN  = 1'b1;
    addr = a;
    nextCycle();
    csN = 1'b1;
    waitReadValid();
  endtask

  task automatic fabricWrite(input logic [8:0] a, input logic [31:0] d);
    xmemEn     = 1'b1;
    xmemWrEn   = 1'b1;
    xmemAddr   = a;
    xmemWrData = d;
    nextCycle();
    xmemEn   = 1'b0;
    xmemWrEn = 1'b0;
  endtask

  task automatic fabricReadWord(input logic [8:0] a);
    xmemEn   = 1'b1;
    xmemWrEn = 1'b0;
    xmemAddr = a;
    nextCycle();
    xmemEn = 1'b0;
    nextCycle();  // Word is checked on this edge
  endtask

  task automatic finishTest(input string name);
    repeat (2) nextCycle();  // Let the last checks fire
    if (failCount == failMark)
    begin
      testsPassed++;
      $display("%-32s ok", name);
    end
    else
    begin
      testsFailed++;
      $display("%-32s %0d check failures", name, failCount - failMark);
    end
    failMark = failCount;
  endtask

  // Timeouts end the run here
  initial
  begin
    @(runAborted);
    $display("%0t ns: %s", $time, abortWhy);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    int         n;
    logic [7:0] pageZeroByte;
    logic [8:0] fabAddr;

    void'($urandom(32'h858dfbfb));
    csN          = 1'b1;
    weN          = 1'b1;
    addr         = 8'h00;
    wrData       = 8'h00;
    memCalDone   = 2'b00;
    ethCoreReady = 1'b0;
    qpllLock     = 1'b0;
    camReady     = 1'b0;
    toeReady     = 1'b0;
    roleRdReg    = 16'h0000;
    xmemEn       = 1'b0;
    xmemWrEn     = 1'b0;
    xmemAddr     = 9'h000;
    xmemWrData   = 32'h0;

    n = 0;
    while (!rstN && n < 10)
    begin
      @(negedge shlClk);
      n++;
    end
    if (!rstN)
    begin
      abortWhy = "reset was never released";
      -> runAborted;
    end
    nextCycle();

    // Reset values while the outputs are compared every cycle
    busRead(8'h00);
    busRead(8'h01);
    busRead(8'h02);
    for (int i = 0; i < 4; i++)
      busRead(8'(8'h70 + i));
    finishTest("reset defaults");

    // Every writable byte read back right away
    for (int i = 0; i < 12; i++)
    begin
      busWrite(8'(8'h34 + i), 8'($urandom));
      busRead(8'(8'h34 + i));
    end
    for (int i = 0; i < 2; i++)
    begin
      busWrite(8'(8'h52 + i), 8'($urandom));
      busRead(8'(8'h52 + i));
    end
    for (int i = 0; i < 5; i++)
    begin
      busWrite(8'(8'h70 + i), 8'($urandom));  // 0x74 drives the loopbacks
      busRead(8'(8'h70 + i));
    end
    finishTest("read/write registers");

    // Status and role inputs then RO and unmapped offsets
    for (int r = 0; r < 3; r++)
    begin
      {memCalDone, ethCoreReady, qpllLock, camReady, toeReady} = 6'($urandom);
      roleRdReg = 16'($urandom);
      busRead(8'h10);
      busRead(8'h50);
      busRead(8'h51);
    end
    busWrite(8'h00, 8'hC2);
    busRead(8'h00);
    busWrite(8'h10, 8'($urandom));
    busRead(8'h10);
    busRead(8'h20);
    busRead(8'h60);
    busWrite(8'h20, 8'($urandom));
    busWrite(8'h60, 8'($urandom));
    busRead(8'h20);
    busRead(8'h60);
    finishTest("read-only and unmapped offsets");

    // Eight reads with no gap between them
    for (int i = 0; i < 8; i++)
    begin
      csN  = 1'b0;
      weN  = 1'b1;
      addr = 8'(i * 9);
      nextCycle();
    end
    csN = 1'b1;
    waitReadValid();
    repeat (4) nextCycle();  // Idle bus with no valid expected
    finishTest("read pipelining");

    // Page 3 written from the bus and seen as fabric word 96
    pageZeroByte = 8'($urandom);
    busWrite(8'h7F, 8'h00);
    busWrite(8'h80, pageZeroByte);
    busWrite(8'h7F, 8'h03);
    busWrite(8'h80, ~pageZeroByte);  // Differs from the page 0 byte
    for (int i = 1; i < 4; i++)
      busWrite(8'(8'h80 + i), 8'($urandom));
    fabricReadWord(9'd96);
    busWrite(8'h7F, 8'h00);
    busRead(8'h80);
    finishTest("paged memory from bus");

    // Fabric words read back through the upper window
    for (int r = 0; r < 3; r++)
    begin
      fabAddr = 9'($urandom);
      fabricWrite(fabAddr, $urandom);
      busWrite(8'h7F, {4'b0000, fabAddr[8:5]});  // Page is word address / 32
      for (int k = 0; k < 4; k++)
        busRead({1'b1, fabAddr[4:0], 2'(k)});
      fabricReadWord(fabAddr);
    end
    finishTest("paged memory from fabric");

    $display("tests passed %0d, tests failed %0d, check failures %0d",
             testsPassed, testsFailed, failCount);
    if (testsFailed == 0 && failCount == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- mmioRegFile.sv
// Only the listed offsets are implemented; all others read 0 and drop writes

`timescale 1ns/1ps

module mmioRegFile (
  input  logic             shlClk,
  input  logic             rstN,
  emifAccessIf.target      regAccess,
  // Status inputs
  input  logic [1:0]       memCalDone,
  input  logic             ethCoreReady,
  input  logic             qpllLock,
  input  logic             camReady,
  input  logic             toeReady,
  input  logic [15:0]      roleRdReg,
  // Control outputs
  output logic [31:0]      ipAddress,
  output logic [31:0]      subNetMask,
  output logic [31:0]      gatewayAddr,
  output logic [15:0]      roleWrReg,
  output logic             pcsLoopbackEn,
  output logic             macLoopbackEn,
  output emifPkg::busByteT pageSel
);

  logic [31:0]      scratch;    // DIAG scratch bytes
  emifPkg::busByteT diagCtrl1;  // Loopback control
  emifPkg::busByteT phyStat;    // Assembled status byte
  emifPkg::busByteT rdMux;      // Selected read byte
  logic [4:0]       bytePos;    // Bit offset inside a 4-byte register
  logic [3:0]       halfPos;    // Bit offset inside a 2-byte register

  assign bytePos = {regAccess.addr[1:0], 3'b000};
  assign halfPos = {regAccess.addr[0], 3'b000};

  // ----------------------------------------------------------------------
  // Writable registers
  // ----------------------------------------------------------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      ipAddress   <= mmioRegPkg::cDefIp;
      subNetMask  <= mmioRegPkg::cDefSnm;
      gatewayAddr <= mmioRegPkg::cDefGtw;
      roleWrReg   <= mmioRegPkg::cDefRoleWr;
      scratch     <= mmioRegPkg::cDefScratch;
      diagCtrl1   <= mmioRegPkg::cDefDiagCtrl1;
      pageSel     <= mmioRegPkg::cDefPageSel;
    end
    else if (regAccess.sel && regAccess.wrEn)
    begin
      case (regAccess.addr) inside
        [mmioRegPkg::cRegLy3Ip : mmioRegPkg::cRegLy3Ip + 7'd3]:
          ipAddress[bytePos +: 8] <= regAccess.wrData;
        [mmioRegPkg::cRegLy3Snm : mmioRegPkg::cRegLy3Snm + 7'd3]:
          subNetMask[bytePos +: 8] <= regAccess.wrData;
        [mmioRegPkg::cRegLy3Gtw : mmioRegPkg::cRegLy3Gtw + 7'd3]:
          gatewayAddr[bytePos +: 8] <= regAccess.wrData;
        [mmioRegPkg::cRegAppWrRol : mmioRegPkg::cRegAppWrRol + 7'd1]:
          roleWrReg[halfPos +: 8] <= regAccess.wrData;
        [mmioRegPkg::cRegDiagScratch : mmioRegPkg::cRegDiagScratch + 7'd3]:
          scratch[bytePos +: 8] <= regAccess.wrData;
        mmioRegPkg::cRegDiagCtrl1: diagCtrl1 <= regAccess.wrData;
        mmioRegPkg::cRegPageSel:   pageSel   <= regAccess.wrData;
        default: ;  // RO or unmapped offset
      endcase
    end
  end

  // Loopback enables straight from DIAG_CTRL_1
  assign pcsLoopbackEn = diagCtrl1[0];
  assign macLoopbackEn = diagCtrl1[1];

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------
  assign phyStat = {2'b00, toeReady, camReady, qpllLock, ethCoreReady, memCalDone};

  always_comb
  begin
    rdMux = '0;  // Unmapped reads as zero
    case (regAccess.addr) inside
      mmioRegPkg::cRegEmifId:  rdMux = mmioRegPkg::cEmifIdVal;
      mmioRegPkg::cRegEmifVer: rdMux = mmioRegPkg::cEmifVerVal;
      mmioRegPkg::cRegEmifRev: rdMux = mmioRegPkg::cEmifRevVal;
      mmioRegPkg::cRegPhyStat: rdMux = phyStat;
      [mmioRegPkg::cRegLy3Ip : mmioRegPkg::cRegLy3Ip + 7'd3]:
        rdMux = ipAddress[bytePos +: 8];
      [mmioRegPkg::cRegLy3Snm : mmioRegPkg::cRegLy3Snm + 7'd3]:
        rdMux = subNetMask[bytePos +: 8];
      [mmioRegPkg::cRegLy3Gtw : mmioRegPkg::cRegLy3Gtw + 7'd3]:
        rdMux = gatewayAddr[bytePos +: 8];
      [mmioRegPkg::cRegAppRdRol : mmioRegPkg::cRegAppRdRol + 7'd1]:
        rdMux = roleRdReg[halfPos +: 8];   // Live role input
      [mmioRegPkg::cRegAppWrRol : mmioRegPkg::cRegAppWrRol + 7'd1]:
        rdMux = roleWrReg[halfPos +: 8];
      [mmioRegPkg::cRegDiagScratch : mmioRegPkg::cRegDiagScratch + 7'd3]:
        rdMux = scratch[bytePos +: 8];
      mmioRegPkg::cRegDiagCtrl1: rdMux = diagCtrl1;
      mmioRegPkg::cRegPageSel:   rdMux = pageSel;
      default: ;
    endcase
  end

  // One-cycle read, held between reads
  always_ff @(posedge shlClk)
  begin
    if (regAccess.sel && !regAccess.wrEn)
      regAccess.rdData <= rdMux;
  end

  // A read of the ID offset must return the fixed ID next cycle
  emifIdFixed: assert property (@(posedge shlClk) disable iff (!rstN)
    regAccess.sel && !regAccess.wrEn && regAccess.addr == mmioRegPkg::cRegEmifId
    |=> regAccess.rdData == mmioRegPkg::cEmifIdVal)
    else $error("EMIF ID byte changed");

endmodule

//--- mmioRegPkg.sv
// Register offsets are 7-bit window offsets; multi-byte registers are little endian by offset

package mmioRegPkg;

  // ----------------------------------------------------------------------
  // Register offsets in the lower window
  // ----------------------------------------------------------------------
  // Config block
  localparam emifPkg::winAddrT cRegEmifId  = 7'h00;  // RO
  localparam emifPkg::winAddrT cRegEmifVer = 7'h01;  // RO
  localparam emifPkg::winAddrT cRegEmifRev = 7'h02;  // RO

  // Physical status
  localparam emifPkg::winAddrT cRegPhyStat = 7'h10;  // RO, from status pins

  // Layer-3 config, 4 bytes each
  localparam emifPkg::winAddrT cRegLy3Ip  = 7'h34;
  localparam emifPkg::winAddrT cRegLy3Snm = 7'h38;
  localparam emifPkg::winAddrT cRegLy3Gtw = 7'h3C;

  // Role words, 2 bytes each
  localparam emifPkg::winAddrT cRegAppRdRol = 7'h50;  // RO
  localparam emifPkg::winAddrT cRegAppWrRol = 7'h52;  // RW

  // Diagnostics
  localparam emifPkg::winAddrT cRegDiagScratch = 7'h70;  // 4 scratch bytes
  localparam emifPkg::winAddrT cRegDiagCtrl1   = 7'h74;  // Loopback enables

  // Page select for the upper window
  localparam emifPkg::winAddrT cRegPageSel = 7'h7F;

  // ----------------------------------------------------------------------
  // Fixed identification
  // ----------------------------------------------------------------------
  localparam emifPkg::busByteT cEmifIdVal  = 8'h3D;
  localparam emifPkg::busByteT cEmifVerVal = 8'h01;
  localparam emifPkg::busByteT cEmifRevVal = 8'h00;

  // ----------------------------------------------------------------------
  // Reset defaults
  // ----------------------------------------------------------------------
  // Byte at base+n sits in bits 8n+7:8n
  localparam logic [31:0] cDefIp      = 32'h13C80C0A;  // 10.12.200.19
  localparam logic [31:0] cDefSnm     = 32'h0000FFFF;  // 255.255.0.0
  localparam logic [31:0] cDefGtw     = 32'h01000C0A;  // 10.12.0.1
  localparam logic [31:0] cDefScratch = 32'hEFBEADDE;  // DE AD BE EF by offset

  // Everything else comes up cleared
  localparam logic [15:0]      cDefRoleWr    = 16'h0000;
  localparam emifPkg::busByteT cDefDiagCtrl1 = 8'h00;
  localparam emifPkg::busByteT cDefPageSel   = 8'h00;

endpackage

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log

verilator --binary --timing --assert --top-module mmioClientTb -f sources.f -o simv \
  > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  ; grep -q "^TEST PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- sources.f
emifPkg.sv
mmioRegPkg.sv
emifAccessIf.sv
emifDecoder.sv
mmioRegFile.sv
xmemDpram.sv
mmioClient.sv
tbClockGen.sv
mmioClientTb.sv

//--- tbClockGen.sv
// Free-running 10 ns clock; rstN held low for the first two rising edges, released 1 ns after

`timescale 1ns/1ps

module tbClockGen (
  output logic shlClk,
  output logic rstN
);

  // 10 ns period
  initial
  begin
    shlClk = 1'b0;
    forever #5 shlClk = ~shlClk;
  end

  // Reset released on the same 1 ns offset as stimulus
  initial
  begin
    rstN = 1'b0;
    repeat (2) @(posedge shlClk);
    #1 rstN = 1'b1;
  end

endmodule

//--- xmemDpram.sv
// Same-cycle writes from both ports to one word are undefined; only page bits 3:0 are used

`timescale 1ns/1ps

module xmemDpram (
  input  logic                              shlClk,
  input  emifPkg::busByteT                  pageSel,
  emifAccessIf.target                       xmemAccess,
  // Fabric port
  input  logic                              xmemEn,
  input  logic                              xmemWrEn,
  input  logic [emifPkg::cFabAddrWidth-1:0] xmemAddr,
  input  emifPkg::fabWordT                  xmemWrData,
  output emifPkg::fabWordT                  xmemRdData
);

  emifPkg::busByteT                   mem [emifPkg::cRamBytes];  // Byte array
  logic [emifPkg::cRamAddrAWidth-1:0] byteAddr;                  // Page plus offset

  // Page bits above the window offset
  assign byteAddr = {pageSel[emifPkg::cRamAddrAWidth-emifPkg::cWinAddrWidth-1:0],
                     xmemAccess.addr};

  // ----------------------------------------------------------------------
  // Both ports on the shell clock
  // ----------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    // Byte port from the bus
    if (xmemAccess.sel)
    begin
      if (xmemAccess.wrEn)
        mem[byteAddr] <= xmemAccess.wrData;
      else
        xmemAccess.rdData <= mem[byteAddr];  // Held until next read
    end

    // Word port from the fabric, byte k in bits 8k+7:8k
    if (xmemEn)
    begin
      for (int k = 0; k < emifPkg::cFabDataWidth / emifPkg::cBusDataWidth; k++)
      begin
        if (xmemWrEn)
          mem[{xmemAddr, 2'(k)}] <= xmemWrData[8*k +: 8];
        else
          xmemRdData[8*k +: 8] <= mem[{xmemAddr, 2'(k)}];
      end
    end
  end

  // Fabric must drive a clean address when enabled
  fabAddrKnown: assert property (@(posedge shlClk)
    xmemEn |-> !$isunknown(xmemAddr))
    else $error("xmemAddr unknown while xmemEn high");

endmodule
